//--- common/ternary_macros.svh
/* size macros for the ternary matrix-vector multiplier:
   input count, row count, input width, result width and carry width. */
`ifndef TERNARY_MACROS_SVH
`define TERNARY_MACROS_SVH

// number of inputs in the vector, one column of the matrix each.
`define TM_IN_LEN 8

// number of output rows.
`define TM_OUT_LEN 4

// signed input width.
`define TM_IN_BITS 8

// signed result width, wide enough for the largest row sum (+1024 here).
`define TM_OUT_BITS 12

// per-row carry width, must hold the input count.
`define TM_CARRY_BITS 4

`endif

//--- common/ternary_pkg.sv
/* weight code enum and matrix, operand and result types. */
`default_nettype none

`include "ternary_macros.svh"

package ternary_pkg;

  // the negative bit wins, so code 2'b11 behaves as NEG.
  typedef enum logic [1:0] {
    ZERO = 2'b00,
    POS  = 2'b01,
    NEG  = 2'b10
  } ternary_e;

  typedef ternary_e [`TM_IN_LEN-1:0] weight_row_t;   // one code per input.
  typedef weight_row_t [`TM_OUT_LEN-1:0] weight_mat_t;

  typedef logic signed [`TM_IN_BITS-1:0] operand_t;
  typedef operand_t [`TM_IN_LEN-1:0] operand_vec_t;

  typedef logic signed [`TM_OUT_BITS-1:0] result_t;
  typedef result_t [`TM_OUT_LEN-1:0] result_vec_t;

endpackage

`default_nettype wire

//--- common/bit_stream_if.sv
/* serial operand stream from the serializer to the row array. */
`default_nettype none

`include "ternary_macros.svh"

interface bit_stream_if;

  // one bit per input, least significant step first.
  logic [`TM_IN_LEN-1:0] bits;

  logic first;   // step zero of a product.
  logic last;    // final step, bit TM_OUT_BITS-1.
  logic active;  // high on every step of a product.

  modport src (
    output bits,
    output first,
    output last,
    output active
  );

  modport dst (
    input bits,
    input first,
    input last,
    input active
  );

endinterface

`default_nettype wire

//--- logic/weight_store.sv
/* register matrix of ternary weight codes, one write per strobe. */
`default_nettype none

`include "ternary_macros.svh"

module weight_store
  import ternary_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we,
  input  logic [$clog2(`TM_OUT_LEN)-1:0] row,
  input  logic [$clog2(`TM_IN_LEN)-1:0]  col,
  input  ternary_e                      code,
  input  logic                          lock,
  output weight_mat_t                   weights
);

  // the row array reads the matrix on every step, so it stays frozen
  // while a product is in flight.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < `TM_OUT_LEN; r++) begin
        for (int c = 0; c < `TM_IN_LEN; c++) begin
          weights[r][c] <= ZERO;
        end
      end
    end else if (we && !lock) begin
      weights[row][col] <= code;
    end
  end

  // the host must address a real cell of the matrix.
  a_index_range: assert property (
    @(posedge clk) disable iff (rst)
    we |-> ((row < `TM_OUT_LEN) && (col < `TM_IN_LEN))
  );

endmodule

`default_nettype wire

//--- matvec/operand_serializer.sv
/* input vector latch and lsb-first serializer with sign extension. */
`default_nettype none

`include "ternary_macros.svh"

module operand_serializer
  import ternary_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  operand_vec_t x,
  input  logic         done_in,
  output logic         busy,
  bit_stream_if.src    stream
);

  localparam int STEP_BITS = $clog2(`TM_OUT_BITS);

  operand_vec_t         sh;
  logic [STEP_BITS-1:0] step;
  logic                 busy_q;
  logic                 accept;

  // busy drops in the cycle the collector shows done.
  assign busy   = busy_q && !done_in;
  assign accept = start && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q        <= 1'b0;
      stream.active <= 1'b0;
      stream.first  <= 1'b0;
      stream.last   <= 1'b0;
      step          <= '0;
    end else if (accept) begin
      busy_q        <= 1'b1;
      stream.active <= 1'b1;
      stream.first  <= 1'b1;
      stream.last   <= 1'b0;
      step          <= '0;
    end else begin
      if (done_in) busy_q <= 1'b0;
      if (stream.active) begin
        stream.first  <= 1'b0;
        stream.last   <= (step == STEP_BITS'(`TM_OUT_BITS - 2));
        stream.active <= !stream.last;  // the step after last ends the product.
        step          <= step + 1'b1;
      end
    end
  end

  // the msb is copied down, so steps above the input width repeat the sign.
  always_ff @(posedge clk) begin
    if (accept) begin
      sh <= x;
    end else if (stream.active) begin
      for (int i = 0; i < `TM_IN_LEN; i++) begin
        sh[i] <= {sh[i][`TM_IN_BITS-1], sh[i][`TM_IN_BITS-1:1]};
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `TM_IN_LEN; i++) begin
      stream.bits[i] = sh[i][0];
    end
  end

  // tags are only meaningful on steps of a running product.
  a_tags_in_active: assert property (
    @(posedge clk) disable iff (rst)
    (stream.first || stream.last) |-> stream.active
  );

endmodule

`default_nettype wire

//--- matvec/ternary_row_array.sv
/* one bit-serial ternary adder per row with negative-weight correction. */
`default_nettype none

`include "ternary_macros.svh"

module ternary_row_array
  import ternary_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  weight_mat_t            weights,
  bit_stream_if.dst              stream,
  output logic [`TM_OUT_LEN-1:0] row_bits,
  output logic                   row_first,
  output logic                   row_last,
  output logic                   row_valid
);

  localparam int SUM_BITS = `TM_CARRY_BITS + 1;

  logic [`TM_OUT_LEN-1:0] sum_lsb;

  for (genvar r = 0; r < `TM_OUT_LEN; r++) begin : g_row
    logic [`TM_CARRY_BITS-1:0] carry;
    logic [`TM_CARRY_BITS-1:0] neg_count;
    logic [`TM_CARRY_BITS-1:0] carry_in;
    logic [`TM_IN_LEN-1:0]     term;
    logic [SUM_BITS-1:0]       sum;

    always_comb begin
      logic [1:0] code;
      neg_count = '0;
      for (int i = 0; i < `TM_IN_LEN; i++) begin
        code = weights[r][i];
        if (code[1]) begin
          term[i]   = ~stream.bits[i];   // ones' complement, the +1 comes from neg_count.
          neg_count = neg_count + 1'b1;
        end else if (code == POS) begin
          term[i] = stream.bits[i];
        end else begin
          term[i] = 1'b0;
        end
      end
      carry_in = stream.first ? neg_count : carry;
      sum      = SUM_BITS'(carry_in);
      for (int i = 0; i < `TM_IN_LEN; i++) begin
        sum = sum + SUM_BITS'(term[i]);
      end
    end

    assign sum_lsb[r] = sum[0];

    always_ff @(posedge clk) begin
      if (rst) begin
        carry <= '0;
      end else if (stream.active) begin
        carry <= sum[SUM_BITS-1:1];
      end
    end

    // at most TM_IN_LEN terms plus a carry of at most TM_IN_LEN, halved.
    a_carry_bound: assert property (
      @(posedge clk) disable iff (rst)
      carry <= `TM_CARRY_BITS'(`TM_IN_LEN)
    );
  end

  always_ff @(posedge clk) begin
    row_bits <= sum_lsb;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      row_first <= 1'b0;
      row_last  <= 1'b0;
      row_valid <= 1'b0;
    end else begin
      row_first <= stream.first;
      row_last  <= stream.last;
      row_valid <= stream.active;
    end
  end

endmodule

`default_nettype wire

//--- matvec/result_collector.sv
/* deserializer for the row results with a one-cycle done pulse. */
`default_nettype none

`include "ternary_macros.svh"

module result_collector
  import ternary_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`TM_OUT_LEN-1:0] row_bits,
  input  logic                   row_first,
  input  logic                   row_last,
  input  logic                   row_valid,
  output result_vec_t            y,
  output logic                   done
);

  result_vec_t acc;
  logic        pend;  // last bit is in acc, publish on the next edge.

  // bits enter at the top, so after TM_OUT_BITS steps the lsb sits at bit 0.
  always_ff @(posedge clk) begin
    if (row_valid) begin
      for (int r = 0; r < `TM_OUT_LEN; r++) begin
        if (row_first) begin
          acc[r] <= {row_bits[r], {(`TM_OUT_BITS-1){1'b0}}};
        end else begin
          acc[r] <= {row_bits[r], acc[r][`TM_OUT_BITS-1:1]};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= 1'b0;
      done <= 1'b0;
      y    <= '0;
    end else begin
      pend <= row_valid && row_last;
      done <= pend;
      if (pend) y <= acc;
    end
  end

  a_tags_need_valid: assert property (
    @(posedge clk) disable iff (rst)
    (row_first || row_last) |-> row_valid
  );

endmodule

`default_nettype wire

//--- logic/matvec_top.sv
/* top level of the ternary matrix-vector multiplier. */
`default_nettype none

`include "ternary_macros.svh"

module matvec_top
  import ternary_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          w_we,
  input  logic [$clog2(`TM_OUT_LEN)-1:0] w_row,
  input  logic [$clog2(`TM_IN_LEN)-1:0]  w_col,
  input  ternary_e                      w_code,
  input  operand_vec_t                  x_in,
  input  logic                          start,
  output result_vec_t                   y_out,
  output logic                          done,
  output logic                          busy
);

  weight_mat_t            weights;
  logic [`TM_OUT_LEN-1:0] row_bits;
  logic                   row_first;
  logic                   row_last;
  logic                   row_valid;

  bit_stream_if u_stream ();

  weight_store u_weights (
    .clk     (clk),
    .rst     (rst),
    .we      (w_we),
    .row     (w_row),
    .col     (w_col),
    .code    (w_code),
    .lock    (busy),       // writes during a product are dropped.
    .weights (weights)
  );

  operand_serializer u_serializer (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .x       (x_in),
    .done_in (done),
    .busy    (busy),
    .stream  (u_stream.src)
  );

  ternary_row_array u_rows (
    .clk       (clk),
    .rst       (rst),
    .weights   (weights),
    .stream    (u_stream.dst),
    .row_bits  (row_bits),
    .row_first (row_first),
    .row_last  (row_last),
    .row_valid (row_valid)
  );

  result_collector u_collector (
    .clk       (clk),
    .rst       (rst),
    .row_bits  (row_bits),
    .row_first (row_first),
    .row_last  (row_last),
    .row_valid (row_valid),
    .y         (y_out),
    .done      (done)
  );

endmodule

`default_nettype wire

//--- tests/tb_matvec.sv
/* directed testbench for the ternary matrix-vector multiplier with a
   reference model, value checks, a watchdog and six test tasks. */
`default_nettype none

`include "ternary_macros.svh"

module tb_matvec
  import ternary_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROW_BITS = $clog2(`TM_OUT_LEN);
  localparam int COL_BITS = $clog2(`TM_IN_LEN);
  localparam int IN_BITS  = `TM_IN_BITS;
  localparam int LATENCY  = `TM_OUT_BITS + 2;  // cycles from the start edge to done.
  // 40 products of 20 cycles, 30 full matrix loads and some idle time.
  localparam int LIMIT_NS = (40 * 20 + 30 * `TM_OUT_LEN * `TM_IN_LEN + 200) * 10;

  logic                clk;
  logic                rst;
  logic                w_we;
  logic [ROW_BITS-1:0] w_row;
  logic [COL_BITS-1:0] w_col;
  ternary_e            w_code;
  operand_vec_t        x_in;
  logic                start;
  result_vec_t         y_out;
  logic                done;
  logic                busy;

  logic [1:0] wm [`TM_OUT_LEN][`TM_IN_LEN];  // model of the weight matrix.
  int         xv [`TM_IN_LEN];               // model of the input vector.
  int         seed = 32'he42af744;
  int         latency;

  matvec_top u_dut (
    .clk    (clk),
    .rst    (rst),
    .w_we   (w_we),
    .w_row  (w_row),
    .w_col  (w_col),
    .w_code (w_code),
    .x_in   (x_in),
    .start  (start),
    .y_out  (y_out),
    .done   (done),
    .busy   (busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    if (why != "") $display("ERROR: %s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped after a failure");
  endtask

  initial begin
    #(LIMIT_NS);
    abort_run("watchdog timeout, the tests did not finish in time");
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      abort_run("");
    end
  endtask

  // -1 when the negative bit is set, +1 for the positive code, else 0.
  function automatic int expected_row(input int r);
    int acc;
    acc = 0;
    for (int c = 0; c < `TM_IN_LEN; c++) begin
      if (wm[r][c][1]) acc -= xv[c];
      else if (wm[r][c] == 2'b01) acc += xv[c];
    end
    return acc;
  endfunction

  function automatic int rand_operand();
    logic signed [IN_BITS-1:0] v;
    v = IN_BITS'($random(seed));
    return int'(v);
  endfunction

  task automatic write_weight(input int r, input int c, input logic [1:0] code);
    w_we   = 1'b1;
    w_row  = ROW_BITS'(r);
    w_col  = COL_BITS'(c);
    w_code = ternary_e'(code);
    tick();
    w_we     = 1'b0;
    wm[r][c] = code;
  endtask

  task automatic load_random(input bit new_weights);
    for (int r = 0; r < `TM_OUT_LEN && new_weights; r++) begin
      for (int c = 0; c < `TM_IN_LEN; c++) write_weight(r, c, 2'($random(seed)));
    end
    for (int c = 0; c < `TM_IN_LEN; c++) xv[c] = rand_operand();
  endtask

  // runs one product and tries a second start or a weight write at a positive poke_at.
  task automatic run_product(input int poke_at, input bit poke_write);
    int cycles;
    for (int i = 0; i < `TM_IN_LEN; i++) x_in[i] = IN_BITS'(xv[i]);
    start = 1'b1;
    tick();
    start  = 1'b0;
    cycles = 0;
    while (!done && cycles < LATENCY) begin
      check_value("busy", 32'(busy), 1);
      if (poke_at > 0 && cycles == poke_at) begin
        if (poke_write) begin
          w_we   = 1'b1;
          w_row  = '0;
          w_col  = '0;
          w_code = (wm[0][0] == 2'b01) ? NEG : POS;  // model keeps the old code.
        end else begin
          x_in  = ~x_in;
          start = 1'b1;
        end
      end
      tick();
      start  = 1'b0;
      w_we   = 1'b0;
      cycles = cycles + 1;
    end
    if (!done) abort_run("done did not arrive within 14 cycles of start");
    latency = cycles;
    check_value("busy", 32'(busy), 0);
    for (int r = 0; r < `TM_OUT_LEN; r++) begin
      check_value($sformatf("y_out[%0d]", r), 32'($signed(y_out[r])), expected_row(r));
    end
    tick();
    check_value("done", 32'(done), 0);
  endtask

  task automatic test_reset();
    check_value("busy", 32'(busy), 0);
    check_value("done", 32'(done), 0);
    for (int r = 0; r < `TM_OUT_LEN; r++) check_value("y_out", 32'(y_out[r]), 0);
    load_random(1'b0);
    run_product(0, 1'b0);
  endtask

  task automatic test_single();
    for (int r = 0; r < `TM_OUT_LEN; r++) begin
      for (int c = 0; c < `TM_IN_LEN; c++) write_weight(r, c, (r == c) ? 2'b01 : 2'b00);
    end
    load_random(1'b0);
    xv[0] = -128;
    xv[1] = 127;
    run_product(0, 1'b0);
    xv[0] = 127;
    xv[1] = -128;
    xv[2] = -128;
    xv[3] = 127;
    run_product(0, 1'b0);
  endtask

  task automatic test_negative();
    for (int r = 0; r < `TM_OUT_LEN; r++) begin
      for (int c = 0; c < `TM_IN_LEN; c++) write_weight(r, c, 2'b10);
    end
    for (int c = 0; c < `TM_IN_LEN; c++) xv[c] = -128;
    run_product(0, 1'b0);
    check_value("y_out[0]", 32'(y_out[0]), 1024);  // largest sum the width must hold.
    for (int r = 0; r < `TM_OUT_LEN; r++) begin
      for (int c = 0; c < `TM_IN_LEN; c++) write_weight(r, c, 2'((r + c) % 3));
    end
    for (int c = 0; c < `TM_IN_LEN; c++) xv[c] = (c % 2 == 1) ? 127 : -128;
    run_product(0, 1'b0);
  endtask

  task automatic test_random();
    for (int n = 0; n < 20; n++) begin
      load_random(1'b1);
      run_product(0, 1'b0);
    end
  endtask

  task automatic test_timing();
    load_random(1'b0);
    run_product(5, 1'b0);
    check_value("latency", latency, LATENCY);
    for (int n = 0; n < 2 * LATENCY; n++) begin
      check_value("done", 32'(done), 0);  // the ignored start must not produce a result.
      check_value("busy", 32'(busy), 0);
      tick();
    end
  endtask

  task automatic test_locked_write();
    load_random(1'b1);
    run_product(5, 1'b1);
    load_random(1'b0);
    xv[0] = -77;  // a nonzero input makes the old and the new weight give different sums.
    run_product(0, 1'b0);
  endtask

  initial begin
    rst    = 1'b1;
    w_we   = 1'b0;
    w_row  = '0;
    w_col  = '0;
    w_code = ZERO;
    x_in   = '0;
    start  = 1'b0;
    for (int r = 0; r < `TM_OUT_LEN; r++) begin
      for (int c = 0; c < `TM_IN_LEN; c++) wm[r][c] = 2'b00;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_single();
    test_negative();
    test_random();
    test_timing();
    test_locked_write();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/ternary_pkg.sv
common/bit_stream_if.sv
logic/weight_store.sv
matvec/operand_serializer.sv
matvec/ternary_row_array.sv
matvec/result_collector.sv
logic/matvec_top.sv
tests/tb_matvec.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and decide the result from the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_matvec -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_matvec > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "pass message not found in $LOG"
exit 1
